/* slink_pkg.sv */
`default_nettype none

package slink_pkg;

  // ------------------------------
  // Link constants
  // ------------------------------
  localparam int lane_w_c = 8;
  localparam int wc_w_c   = 16;
  localparam int id_w_c   = 8;
  localparam int crc_w_c  = 16;

  localparam logic [crc_w_c-1:0] crc_init_c = '1;
  localparam logic [crc_w_c-1:0] crc_poly_c = 16'h1021;

  typedef enum logic [1:0] {
    FLIT_HDR,
    FLIT_DATA,
    FLIT_LAST,
    FLIT_CRC
  } flit_kind_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_PAYLOAD,
    TX_GAP
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_PAYLOAD,
    RX_CRC,
    RX_DROP
  } rx_state_e;

  // CRC-16-CCITT, one byte, MSB first, no reflection
  function automatic logic [crc_w_c-1:0] crc16_byte(
    input logic [crc_w_c-1:0]  crc,
    input logic [lane_w_c-1:0] data
  );
    logic [crc_w_c-1:0] c;
    c = crc ^ {data, 8'h00};
    for (int i = 0; i < lane_w_c; i++) begin
      c = c[crc_w_c-1] ? ((c << 1) ^ crc_poly_c) : (c << 1);
    end
    return c;
  endfunction

  function automatic logic [lane_w_c-1:0] hdr_checksum(
    input logic [id_w_c-1:0] data_id,
    input logic [wc_w_c-1:0] word_count
  );
    return data_id ^ word_count[7:0] ^ word_count[15:8];
  endfunction

endpackage

`default_nettype wire

/* slink_flit_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface slink_flit_if #(
  parameter int NUM_LANES = 4
);
  import slink_pkg::*;

  logic                               valid;
  flit_kind_e                         kind;
  logic [NUM_LANES-1:0][lane_w_c-1:0] data;
  logic [NUM_LANES-1:0]               byte_en;

  modport source (
    output valid, kind, data, byte_en
  );

  modport sink (
    input valid, kind, data, byte_en
  );

endinterface

`default_nettype wire

/* slink_tx_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module slink_tx_framer #(
  parameter int NUM_LANES = 4
) (
  input  logic                                     link_clk,
  input  logic                                     arst_n,
  input  logic                                     tx_sop,
  input  logic [slink_pkg::id_w_c-1:0]             tx_data_id,
  input  logic [slink_pkg::wc_w_c-1:0]             tx_word_count,
  input  logic [NUM_LANES*slink_pkg::lane_w_c-1:0] tx_app_data,
  output logic                                     tx_advance,
  slink_flit_if.source                             flit
);
  import slink_pkg::*;

  localparam logic [wc_w_c-1:0]    LANES_WC = wc_w_c'(NUM_LANES);
  localparam logic [NUM_LANES-1:0] HDR_EN   = NUM_LANES'(4'hf);

  tx_state_e                          state;
  logic [wc_w_c-1:0]                  bytes_left;
  logic                               last_word;
  logic [NUM_LANES-1:0]               lane_en;
  logic [NUM_LANES-1:0][lane_w_c-1:0] app_lanes;
  logic [NUM_LANES-1:0][lane_w_c-1:0] pay_lanes;
  logic [NUM_LANES-1:0][lane_w_c-1:0] hdr_lanes;

  assign app_lanes  = tx_app_data;
  assign last_word  = (bytes_left <= LANES_WC);
  assign tx_advance = (state == TX_PAYLOAD);

  // Byte enables and zero padding for the current word
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_en[i]   = (bytes_left > wc_w_c'(i));
      pay_lanes[i] = lane_en[i] ? app_lanes[i] : '0;
    end
  end

  always_comb begin
    hdr_lanes    = '0;
    hdr_lanes[0] = tx_data_id;
    hdr_lanes[1] = tx_word_count[7:0];
    hdr_lanes[2] = tx_word_count[15:8];
    hdr_lanes[3] = hdr_checksum(tx_data_id, tx_word_count);
  end

  always_ff @(posedge link_clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= TX_IDLE;
      bytes_left <= '0;
      flit.valid <= 1'b0;
    end else begin
      case (state)
        TX_IDLE: begin
          flit.valid <= tx_sop;
          if (tx_sop) begin
            bytes_left <= tx_word_count;
            state      <= TX_PAYLOAD;
          end
        end
        TX_PAYLOAD: begin
          flit.valid <= 1'b1;
          if (last_word) begin
            state <= TX_GAP;
          end else begin
            bytes_left <= bytes_left - LANES_WC;
          end
        end
        // Free slot for the CRC flit
        default: begin
          flit.valid <= 1'b0;
          state      <= TX_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge link_clk) begin
    if (state == TX_IDLE) begin
      flit.kind    <= FLIT_HDR;
      flit.data    <= hdr_lanes;
      flit.byte_en <= HDR_EN;
    end else begin
      flit.kind    <= last_word ? FLIT_LAST : FLIT_DATA;
      flit.data    <= pay_lanes;
      flit.byte_en <= lane_en;
    end
  end

  a_sop_wc_nonzero: assert property (
    @(posedge link_clk) disable iff (!arst_n)
    (state == TX_IDLE && tx_sop) |-> (tx_word_count != '0)
  );

endmodule

`default_nettype wire

/* slink_tx_crc.sv */
`timescale 1ns/1ps
`default_nettype none

module slink_tx_crc #(
  parameter int NUM_LANES = 4
) (
  input  logic                                     link_clk,
  input  logic                                     arst_n,
  slink_flit_if.sink                               flit,
  output logic                                     phy_tx_valid,
  output logic [NUM_LANES*slink_pkg::lane_w_c-1:0] phy_tx_data
);
  import slink_pkg::*;

  flit_kind_e                         out_kind;
  logic                               insert_crc;
  logic [crc_w_c-1:0]                 crc_q;
  logic [crc_w_c-1:0]                 crc_next;
  logic [NUM_LANES-1:0][lane_w_c-1:0] crc_lanes;

  // CRC goes out right after the last payload flit
  assign insert_crc = phy_tx_valid && (out_kind == FLIT_LAST);

  always_comb begin
    crc_next = (flit.kind == FLIT_HDR) ? crc_init_c : crc_q;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (flit.byte_en[i] && (flit.kind inside {FLIT_DATA, FLIT_LAST})) begin
        crc_next = crc16_byte(crc_next, flit.data[i]);
      end
    end
  end

  always_comb begin
    crc_lanes    = '0;
    crc_lanes[0] = crc_q[7:0];
    crc_lanes[1] = crc_q[15:8];
  end

  always_ff @(posedge link_clk or negedge arst_n) begin
    if (!arst_n) begin
      crc_q        <= crc_init_c;
      phy_tx_valid <= 1'b0;
      out_kind     <= FLIT_HDR;
    end else begin
      if (flit.valid) begin
        crc_q <= crc_next;
      end
      phy_tx_valid <= flit.valid || insert_crc;
      out_kind     <= insert_crc ? FLIT_CRC : flit.kind;
    end
  end

  always_ff @(posedge link_clk) begin
    phy_tx_data <= insert_crc ? crc_lanes : flit.data;
  end

  // Framer must leave the CRC slot empty
  a_crc_slot_free: assert property (
    @(posedge link_clk) disable iff (!arst_n)
    insert_crc |-> !flit.valid
  );

endmodule

`default_nettype wire

/* slink_rx_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module slink_rx_parser #(
  parameter int NUM_LANES = 4
) (
  input  logic                                     link_clk,
  input  logic                                     arst_n,
  input  logic                                     phy_rx_valid,
  input  logic [NUM_LANES*slink_pkg::lane_w_c-1:0] phy_rx_data,
  output logic                                     rx_hdr_err,
  slink_flit_if.source                             flit
);
  import slink_pkg::*;

  localparam logic [wc_w_c-1:0]    LANES_WC = wc_w_c'(NUM_LANES);
  localparam logic [NUM_LANES-1:0] HDR_EN   = NUM_LANES'(4'hf);
  localparam logic [NUM_LANES-1:0] CRC_EN   = NUM_LANES'(2'b11);

  rx_state_e                          state;
  logic [wc_w_c-1:0]                  bytes_left;
  logic [wc_w_c-1:0]                  hdr_wc;
  logic                               hdr_ok;
  logic                               last_word;
  logic [NUM_LANES-1:0]               lane_en;
  logic [NUM_LANES-1:0][lane_w_c-1:0] rx_lanes;
  logic [NUM_LANES-1:0][lane_w_c-1:0] pay_lanes;

  assign rx_lanes  = phy_rx_data;
  assign hdr_wc    = {rx_lanes[2], rx_lanes[1]};
  assign hdr_ok    = (rx_lanes[3] == hdr_checksum(rx_lanes[0], hdr_wc));
  assign last_word = (bytes_left <= LANES_WC);

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_en[i]   = (bytes_left > wc_w_c'(i));
      pay_lanes[i] = lane_en[i] ? rx_lanes[i] : '0;
    end
  end

  always_ff @(posedge link_clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= RX_IDLE;
      bytes_left <= '0;
      flit.valid <= 1'b0;
      rx_hdr_err <= 1'b0;
    end else begin
      flit.valid <= 1'b0;
      rx_hdr_err <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (phy_rx_valid && hdr_ok) begin
            flit.valid <= 1'b1;
            bytes_left <= hdr_wc;
            state      <= RX_PAYLOAD;
          end else if (phy_rx_valid) begin
            rx_hdr_err <= 1'b1;
            state      <= RX_DROP;
          end
        end
        RX_PAYLOAD: begin
          if (phy_rx_valid) begin
            flit.valid <= 1'b1;
            if (last_word) begin
              state <= RX_CRC;
            end else begin
              bytes_left <= bytes_left - LANES_WC;
            end
          end
        end
        RX_CRC: begin
          if (phy_rx_valid) begin
            flit.valid <= 1'b1;
            state      <= RX_IDLE;
          end
        end
        // Skip the rest of a bad packet
        default: begin
          if (!phy_rx_valid) begin
            state <= RX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge link_clk) begin
    case (state)
      RX_IDLE: begin
        flit.kind    <= FLIT_HDR;
        flit.data    <= rx_lanes;
        flit.byte_en <= HDR_EN;
      end
      RX_PAYLOAD: begin
        flit.kind    <= last_word ? FLIT_LAST : FLIT_DATA;
        flit.data    <= pay_lanes;
        flit.byte_en <= lane_en;
      end
      default: begin
        flit.kind    <= FLIT_CRC;
        flit.data    <= rx_lanes;
        flit.byte_en <= CRC_EN;
      end
    endcase
  end

endmodule

`default_nettype wire

/* slink_rx_crc_check.sv */
`timescale 1ns/1ps
`default_nettype none

module slink_rx_crc_check #(
  parameter int NUM_LANES = 4
) (
  input  logic                                     link_clk,
  input  logic                                     arst_n,
  slink_flit_if.sink                               flit,
  output logic                                     rx_sop,
  output logic [slink_pkg::id_w_c-1:0]             rx_data_id,
  output logic [slink_pkg::wc_w_c-1:0]             rx_word_count,
  output logic [NUM_LANES*slink_pkg::lane_w_c-1:0] rx_app_data,
  output logic                                     rx_valid,
  output logic                                     rx_crc_corrupted
);
  import slink_pkg::*;

  logic [crc_w_c-1:0] crc_q;
  logic [crc_w_c-1:0] crc_next;
  logic [crc_w_c-1:0] crc_rx;
  logic               is_payload;
  logic               after_last;

  assign is_payload = flit.kind inside {FLIT_DATA, FLIT_LAST};
  assign crc_rx     = {flit.data[1], flit.data[0]};

  always_comb begin
    crc_next = (flit.kind == FLIT_HDR) ? crc_init_c : crc_q;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (flit.byte_en[i] && is_payload) begin
        crc_next = crc16_byte(crc_next, flit.data[i]);
      end
    end
  end

  always_ff @(posedge link_clk or negedge arst_n) begin
    if (!arst_n) begin
      crc_q            <= crc_init_c;
      after_last       <= 1'b0;
      rx_sop           <= 1'b0;
      rx_valid         <= 1'b0;
      rx_crc_corrupted <= 1'b0;
    end else begin
      if (flit.valid) begin
        crc_q      <= crc_next;
        after_last <= (flit.kind == FLIT_LAST);
      end
      rx_sop           <= flit.valid && (flit.kind == FLIT_HDR);
      rx_valid         <= flit.valid && is_payload;
      rx_crc_corrupted <= flit.valid && (flit.kind == FLIT_CRC) && (crc_rx != crc_q);
    end
  end

  // Header fields and payload
  always_ff @(posedge link_clk) begin
    if (flit.valid && (flit.kind == FLIT_HDR)) begin
      rx_data_id    <= flit.data[0];
      rx_word_count <= {flit.data[2], flit.data[1]};
    end
    if (flit.valid && is_payload) begin
      rx_app_data <= flit.data;
    end
  end

  a_crc_after_last: assert property (
    @(posedge link_clk) disable iff (!arst_n)
    (flit.valid && flit.kind == FLIT_CRC) |-> after_last
  );

endmodule

`default_nettype wire

/* slink.sv */
`timescale 1ns/1ps
`default_nettype none

module slink #(
  parameter int NUM_LANES = 4
) (
  input  logic                                     link_clk,
  input  logic                                     arst_n,

  // Application TX
  input  logic                                     tx_sop,
  input  logic [slink_pkg::id_w_c-1:0]             tx_data_id,
  input  logic [slink_pkg::wc_w_c-1:0]             tx_word_count,
  input  logic [NUM_LANES*slink_pkg::lane_w_c-1:0] tx_app_data,
  output logic                                     tx_advance,

  // Application RX
  output logic                                     rx_sop,
  output logic [slink_pkg::id_w_c-1:0]             rx_data_id,
  output logic [slink_pkg::wc_w_c-1:0]             rx_word_count,
  output logic [NUM_LANES*slink_pkg::lane_w_c-1:0] rx_app_data,
  output logic                                     rx_valid,
  output logic                                     rx_crc_corrupted,
  output logic                                     rx_hdr_err,

  // PHY
  output logic                                     phy_tx_valid,
  output logic [NUM_LANES*slink_pkg::lane_w_c-1:0] phy_tx_data,
  input  logic                                     phy_rx_valid,
  input  logic [NUM_LANES*slink_pkg::lane_w_c-1:0] phy_rx_data
);

  slink_flit_if #(.NUM_LANES(NUM_LANES)) tx_flit ();
  slink_flit_if #(.NUM_LANES(NUM_LANES)) rx_flit ();

  // ------------------------------
  // TX path
  // ------------------------------
  slink_tx_framer #(
    .NUM_LANES     ( NUM_LANES     )
  ) u_slink_tx_framer (
    .link_clk      ( link_clk      ),
    .arst_n        ( arst_n        ),
    .tx_sop        ( tx_sop        ),
    .tx_data_id    ( tx_data_id    ),
    .tx_word_count ( tx_word_count ),
    .tx_app_data   ( tx_app_data   ),
    .tx_advance    ( tx_advance    ),
    .flit          ( tx_flit       )
  );

  slink_tx_crc #(
    .NUM_LANES     ( NUM_LANES     )
  ) u_slink_tx_crc (
    .link_clk      ( link_clk      ),
    .arst_n        ( arst_n        ),
    .flit          ( tx_flit       ),
    .phy_tx_valid  ( phy_tx_valid  ),
    .phy_tx_data   ( phy_tx_data   )
  );

  // ------------------------------
  // RX path
  // ------------------------------
  slink_rx_parser #(
    .NUM_LANES     ( NUM_LANES     )
  ) u_slink_rx_parser (
    .link_clk      ( link_clk      ),
    .arst_n        ( arst_n        ),
    .phy_rx_valid  ( phy_rx_valid  ),
    .phy_rx_data   ( phy_rx_data   ),
    .rx_hdr_err    ( rx_hdr_err    ),
    .flit          ( rx_flit       )
  );

  slink_rx_crc_check #(
    .NUM_LANES        ( NUM_LANES        )
  ) u_slink_rx_crc_check (
    .link_clk         ( link_clk         ),
    .arst_n           ( arst_n           ),
    .flit             ( rx_flit          ),
    .rx_sop           ( rx_sop           ),
    .rx_data_id       ( rx_data_id       ),
    .rx_word_count    ( rx_word_count    ),
    .rx_app_data      ( rx_app_data      ),
    .rx_valid         ( rx_valid         ),
    .rx_crc_corrupted ( rx_crc_corrupted )
  );

endmodule

`default_nettype wire

/* tb_slink.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_slink;

  localparam int lanes_c = 4;
  localparam int dw_c    = lanes_c * 8;

  // Flits per packet are ceil(wc/4)+2; the random packets count at their largest
  localparam int pkt_flits_c = 4 + (3 + 4 + 4) + 4 + (3 + 5) + 10 * 7;
  localparam int timeout_c   = pkt_flits_c * 4 + 200;

  logic            link_clk;
  logic            arst_n;
  logic            tx_sop;
  logic [7:0]      tx_data_id;
  logic [15:0]     tx_word_count;
  logic [dw_c-1:0] tx_app_data;
  logic            tx_advance;
  logic            rx_sop;
  logic [7:0]      rx_data_id;
  logic [15:0]     rx_word_count;
  logic [dw_c-1:0] rx_app_data;
  logic            rx_valid;
  logic            rx_crc_corrupted;
  logic            rx_hdr_err;
  logic            phy_tx_valid;
  logic [dw_c-1:0] phy_tx_data;
  logic            phy_rx_valid;
  logic [dw_c-1:0] phy_rx_data;
  logic [dw_c-1:0] rx_mask = '0;

  int          errors = 0;
  int          cycles = 0;
  logic [15:0] lfsr = 16'd44178;
  logic [7:0]  pkt_bytes [0:63];

  // Expected and observed traffic
  logic [31:0] exp_id_q [$];
  logic [31:0] exp_wc_q [$];
  logic [31:0] exp_word_q [$];
  logic [31:0] exp_crc_q [$];
  logic [31:0] rx_id_q [$];
  logic [31:0] rx_wc_q [$];
  logic [31:0] rx_word_q [$];
  logic [31:0] seen_crc_q [$];
  int          adv_cnt = 0;
  int          crc_bad_cnt = 0;
  int          hdr_err_cnt = 0;
  int          last_valid_cyc = 0;
  int          crc_bad_cyc = 0;

  // Loopback flit tracking
  logic            s_adv = 1'b0;
  logic            adv_prev = 1'b0;
  logic [15:0]     s_wc = '0;
  int              flit_idx = -1;
  int              crc_idx = -2;
  int              tgt_idx = -2;
  int              corrupt_sel = 0;
  logic [dw_c-1:0] corrupt_mask = '0;

  slink #(
    .NUM_LANES        ( lanes_c          )
  ) dut0 (
    .link_clk         ( link_clk         ),
    .arst_n           ( arst_n           ),
    .tx_sop           ( tx_sop           ),
    .tx_data_id       ( tx_data_id       ),
    .tx_word_count    ( tx_word_count    ),
    .tx_app_data      ( tx_app_data      ),
    .tx_advance       ( tx_advance       ),
    .rx_sop           ( rx_sop           ),
    .rx_data_id       ( rx_data_id       ),
    .rx_word_count    ( rx_word_count    ),
    .rx_app_data      ( rx_app_data      ),
    .rx_valid         ( rx_valid         ),
    .rx_crc_corrupted ( rx_crc_corrupted ),
    .rx_hdr_err       ( rx_hdr_err       ),
    .phy_tx_valid     ( phy_tx_valid     ),
    .phy_tx_data      ( phy_tx_data      ),
    .phy_rx_valid     ( phy_rx_valid     ),
    .phy_rx_data      ( phy_rx_data      )
  );

  assign phy_rx_valid = phy_tx_valid;
  assign phy_rx_data  = phy_tx_data ^ rx_mask;

  initial begin
    link_clk = 1'b0;
    forever #20 link_clk = ~link_clk;
  end

  initial begin
    while (cycles < timeout_c) begin
      @(posedge link_clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, %0d errors", cycles, errors);
    $display("Some tests failed");
    $finish;
  end

  // ------------------------------
  // Monitors
  // ------------------------------
  always @(negedge link_clk) begin
    s_adv = tx_advance;
    s_wc  = tx_word_count;
    if (arst_n) begin
      if (tx_advance) adv_cnt++;
      if (rx_sop) begin
        rx_id_q.push_back(32'(rx_data_id));
        rx_wc_q.push_back(32'(rx_word_count));
      end
      if (rx_valid) begin
        rx_word_q.push_back(rx_app_data);
        last_valid_cyc = cycles;
      end
      if (rx_crc_corrupted) begin
        crc_bad_cnt++;
        crc_bad_cyc = cycles;
      end
      if (rx_hdr_err) hdr_err_cnt++;
      if (flit_idx >= 0 && flit_idx == crc_idx) begin
        if (phy_tx_valid) seen_crc_q.push_back(phy_tx_data);
        else fail_event("CRC flit slot on phy_tx is not valid");
      end
    end
  end

  // Header lands on phy one edge after the first tx_advance cycle
  always @(posedge link_clk) begin
    if (s_adv && !adv_prev) begin
      flit_idx = 0;
      crc_idx  = (s_wc + 3) / 4 + 1;
      case (corrupt_sel)
        1:       tgt_idx = 0;
        2:       tgt_idx = crc_idx;
        default: tgt_idx = -2;
      endcase
    end else if (flit_idx >= 0) begin
      flit_idx++;
    end
    adv_prev = s_adv;
    rx_mask <= (flit_idx == tgt_idx) ? corrupt_mask : '0;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic fail_event(input string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[14:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Bit-serial CRC-16-CCITT over the current packet bytes
  function automatic logic [15:0] crc_model(input int n);
    logic [15:0] c;
    logic        fb;
    c = 16'hFFFF;
    for (int i = 0; i < n; i++) begin
      for (int j = 7; j >= 0; j--) begin
        fb = c[15] ^ pkt_bytes[i][j];
        c  = {c[14:0], 1'b0};
        if (fb) c = c ^ 16'h1021;
      end
    end
    return c;
  endfunction

  function automatic logic [31:0] pack_word(input int k, input int wc, input logic [7:0] pad);
    logic [31:0] w;
    int          idx;
    for (int l = 0; l < lanes_c; l++) begin
      idx        = k * lanes_c + l;
      w[8*l +: 8] = (idx < wc) ? pkt_bytes[idx] : pad;
    end
    return w;
  endfunction

  task automatic send_packet(input logic [7:0] id, input int wc, input bit expect_rx);
    logic [15:0] r;
    int          nw;
    int          k;
    nw = (wc + lanes_c - 1) / lanes_c;
    for (int i = 0; i < wc; i++) begin
      r            = rand_bits(8);
      pkt_bytes[i] = r[7:0];
    end
    if (expect_rx) begin
      exp_id_q.push_back(32'(id));
      exp_wc_q.push_back(32'(wc));
      for (int i = 0; i < nw; i++) exp_word_q.push_back(pack_word(i, wc, 8'h00));
    end
    exp_crc_q.push_back({16'h0000, crc_model(wc)});
    @(posedge link_clk);
    tx_sop        <= 1'b1;
    tx_data_id    <= id;
    tx_word_count <= 16'(wc);
    tx_app_data   <= pack_word(0, wc, 8'hA5);
    k = 0;
    while (k < nw) begin
      @(negedge link_clk);
      if (tx_advance) begin
        @(posedge link_clk);
        tx_sop <= 1'b0;
        k++;
        tx_app_data <= (k < nw) ? pack_word(k, wc, 8'hA5) : '0;
      end
    end
  endtask

  // Waits for all expected traffic, then compares it in order
  task automatic wait_rx();
    int n;
    n = 0;
    while ((rx_word_q.size() < exp_word_q.size() || rx_id_q.size() < exp_id_q.size() ||
            seen_crc_q.size() < exp_crc_q.size()) && n < 100) begin
      @(posedge link_clk);
      n++;
    end
    repeat (3) @(posedge link_clk);
    if (n >= 100) fail_event("expected packet traffic never arrived");
    check_eq("rx_sop count", rx_id_q.size(), exp_id_q.size());
    check_eq("rx_valid count", rx_word_q.size(), exp_word_q.size());
    check_eq("phy_tx CRC flit count", seen_crc_q.size(), exp_crc_q.size());
    while (rx_id_q.size() > 0 && exp_id_q.size() > 0) begin
      check_eq("rx_data_id", rx_id_q.pop_front(), exp_id_q.pop_front());
      check_eq("rx_word_count", rx_wc_q.pop_front(), exp_wc_q.pop_front());
    end
    while (rx_word_q.size() > 0 && exp_word_q.size() > 0) begin
      check_eq("rx_app_data", rx_word_q.pop_front(), exp_word_q.pop_front());
    end
    while (seen_crc_q.size() > 0 && exp_crc_q.size() > 0) begin
      check_eq("phy_tx_data CRC flit", seen_crc_q.pop_front(), exp_crc_q.pop_front());
    end
    rx_id_q.delete();
    rx_wc_q.delete();
    rx_word_q.delete();
    seen_crc_q.delete();
    exp_id_q.delete();
    exp_wc_q.delete();
    exp_word_q.delete();
    exp_crc_q.delete();
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic reset_state_low();
    @(negedge link_clk);
    check_eq("tx_advance", tx_advance, 0);
    check_eq("phy_tx_valid", phy_tx_valid, 0);
    check_eq("rx_sop", rx_sop, 0);
    check_eq("rx_valid", rx_valid, 0);
    check_eq("rx_crc_corrupted", rx_crc_corrupted, 0);
    check_eq("rx_hdr_err", rx_hdr_err, 0);
  endtask

  task automatic single_packet();
    int a0;
    int c0;
    a0 = adv_cnt;
    c0 = crc_bad_cnt;
    send_packet(8'h3C, 8, 1'b1);
    wait_rx();
    check_eq("tx_advance cycles", adv_cnt - a0, 2);
    check_eq("rx_crc_corrupted pulses", crc_bad_cnt - c0, 0);
  endtask

  task automatic back_to_back();
    int c0;
    int h0;
    c0 = crc_bad_cnt;
    h0 = hdr_err_cnt;
    send_packet(8'h11, 1, 1'b1);
    send_packet(8'h22, 5, 1'b1);
    send_packet(8'h33, 7, 1'b1);
    wait_rx();
    check_eq("rx_crc_corrupted pulses", crc_bad_cnt - c0, 0);
    check_eq("rx_hdr_err pulses", hdr_err_cnt - h0, 0);
  endtask

  task automatic crc_flip();
    int c0;
    c0 = crc_bad_cnt;
    corrupt_sel  = 2;
    corrupt_mask = 32'h0000_0010;
    send_packet(8'h5A, 6, 1'b1);
    wait_rx();
    corrupt_sel = 0;
    check_eq("rx_crc_corrupted pulses", crc_bad_cnt - c0, 1);
    check_eq("rx_crc_corrupted after last rx_valid", crc_bad_cyc > last_valid_cyc, 1);
  endtask

  task automatic header_flip();
    int h0;
    h0 = hdr_err_cnt;
    corrupt_sel  = 1;
    corrupt_mask = 32'hFF00_0000;
    send_packet(8'h77, 4, 1'b0);
    wait_rx();
    corrupt_sel = 0;
    check_eq("rx_hdr_err pulses", hdr_err_cnt - h0, 1);
    send_packet(8'h78, 9, 1'b1);
    wait_rx();
    check_eq("rx_hdr_err pulses after good packet", hdr_err_cnt - h0, 1);
  endtask

  task automatic random_packets();
    logic [15:0] id;
    logic [15:0] wc;
    int          c0;
    c0 = crc_bad_cnt;
    for (int p = 0; p < 10; p++) begin
      id = rand_bits(8);
      wc = rand_bits(5);
      send_packet(id[7:0], (wc % 20) + 1, 1'b1);
      wait_rx();
    end
    check_eq("rx_crc_corrupted pulses", crc_bad_cnt - c0, 0);
  endtask

  initial begin
    arst_n        = 1'b0;
    tx_sop        = 1'b0;
    tx_data_id    = '0;
    tx_word_count = '0;
    tx_app_data   = '0;
    repeat (10) @(posedge link_clk);
    arst_n <= 1'b1;
    reset_state_low();
    single_packet();
    back_to_back();
    crc_flip();
    header_flip();
    random_packets();
    $display("tb_slink finished after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
slink_pkg.sv
slink_flit_if.sv
slink_tx_framer.sv
slink_tx_crc.sv
slink_rx_parser.sv
slink_rx_crc_check.sv
slink.sv
tb_slink.sv
